/* hdl/bx_marker.sv */
`timescale 1ns/1ps
`default_nettype none

// Shared header tag for all four fibers
module bx_marker (
  input  wire logic                            clk_40,
  input  wire logic                            link_reset,
  input  wire logic                            ttc_bx0,
  input  wire logic [trg_link_pkg::BXN_W-1:0]  bxn_counter,
  output trg_link_pkg::hdr_kind_t              tag
);

  import trg_link_pkg::*;

  // ----------------------------------------
  // BX classification
  // ----------------------------------------
  logic      lat_due;  // Low bits of bxn all zero
  hdr_kind_t tag_next; // Tag for this BX

  assign lat_due = (bxn_counter[LAT_MARK_PERIOD_LOG2-1:0] == '0); // Once per 128 BX

  always_comb begin
    if (link_reset) begin
      tag_next = HDR_IDLE;  // Link held
    end else if (ttc_bx0) begin
      tag_next = HDR_BC0;   // BC0 beats the latency marker
    end else if (lat_due) begin
      tag_next = HDR_LAT;   // Latency marker
    end else begin
      tag_next = HDR_DATA;  // Plain data BX
    end
  end

  // ----------------------------------------
  // Tag register
  // ----------------------------------------
  // Lines up with the delayed payload in each fiber
  always_ff @(posedge clk_40) begin
    tag <= tag_next; // Registered BX tag
  end

endmodule

`default_nettype wire

/* hdl/fiber_frame_out.sv */
`timescale 1ns/1ps
`default_nettype none

// Frame builder for one trigger fiber
module fiber_frame_out (
  input  wire logic                            clk_40,
  input  wire logic                            link_reset,
  input  trg_link_pkg::link_payload_t          payload,
  input  wire logic [trg_link_pkg::BXN_W-1:0]  bxn_counter,
  input  wire logic                            overflow,
  input  trg_link_pkg::hdr_kind_t              tag,
  output trg_link_pkg::trg_frame_t             frame
);

  import trg_link_pkg::*;

  // ----------------------------------------
  // Input delay to meet the registered tag
  // ----------------------------------------
  link_payload_t    payload_d;   // Clusters one BX late
  logic [BXN_W-1:0] bxn_d;       // BX number one BX late
  logic             overflow_d;  // Overflow one BX late

  always_ff @(posedge clk_40) begin
    payload_d  <= payload;     // Payload register
    bxn_d      <= bxn_counter;
    overflow_d <= overflow;
  end

  // ----------------------------------------
  // Field select
  // ----------------------------------------
  logic             tag_idle;    // Idle header in this BX
  link_payload_t    payload_f;   // Payload as sent
  logic [BXN_W-1:0] bxn_f;       // BX number as sent
  logic             overflow_f;  // Overflow as sent

  assign tag_idle = (tag == HDR_IDLE);

  // Idle frames carry no content, only the tag decides
  always_comb begin
    if (tag_idle) begin
      payload_f  = '0;
      bxn_f      = '0;
      overflow_f = 1'b0;
    end else begin
      payload_f  = payload_d;
      bxn_f      = bxn_d;
      overflow_f = overflow_d;
    end
  end

  // ----------------------------------------
  // CRC
  // ----------------------------------------
  logic [CRC_W-1:0] crc_f;     // CRC of the fields as sent
  logic [CRC_W-1:0] idle_crc;  // CRC of the all zero content

  link_crc8 u_crc (
    .overflow (overflow_f),
    .bxn      (bxn_f),
    .payload  (payload_f),
    .crc      (crc_f)
  );

  // Constant inputs, folds to a fixed value
  link_crc8 u_idle_crc (
    .overflow (1'b0),
    .bxn      ({BXN_W{1'b0}}),
    .payload  ('0),
    .crc      (idle_crc)
  );

  // ----------------------------------------
  // Frame register
  // ----------------------------------------
  trg_frame_t frame_next;  // Assembled frame
  trg_frame_t frame_idle;  // Frame sent while held

  always_comb begin
    frame_next.hdr      = tag;
    frame_next.overflow = overflow_f;
    frame_next.bxn      = bxn_f;
    frame_next.payload  = payload_f;
    frame_next.crc      = crc_f;
  end

  always_comb begin
    frame_idle.hdr      = HDR_IDLE;
    frame_idle.overflow = 1'b0;
    frame_idle.bxn      = '0;
    frame_idle.payload  = '0;
    frame_idle.crc      = idle_crc;
  end

  always_ff @(posedge clk_40) begin
    if (link_reset) begin
      frame <= frame_idle;   // Link held idle
    end else begin
      frame <= frame_next;   // One frame per BX
    end
  end

endmodule

`default_nettype wire

/* hdl/link_crc8.sv */
`timescale 1ns/1ps
`default_nettype none

// CRC-8 over the checked part of a frame
module link_crc8 (
  input  wire logic                                 overflow,
  input  wire logic [trg_link_pkg::BXN_W-1:0]       bxn,
  input  trg_link_pkg::link_payload_t               payload,
  output logic      [7:0]                           crc
);

  import trg_link_pkg::*;

  // ----------------------------------------
  // Checked bits, MSB first
  // ----------------------------------------
  logic [CRC_DATA_W-1:0] crc_data; // Overflow on top, payload at the bottom

  assign crc_data = {overflow, bxn, payload};

  // ----------------------------------------
  // Bitwise unrolled shift register
  // ----------------------------------------
  always_comb begin
    logic [CRC_W-1:0] acc; // Running remainder
    logic             fb;  // Feedback bit

    acc = CRC_INIT;
    for (int i = CRC_DATA_W - 1; i >= 0; i--) begin
      fb  = acc[CRC_W-1] ^ crc_data[i];             // Top bit against next data bit
      acc = {acc[CRC_W-2:0], 1'b0};                 // Shift left
      acc = acc ^ (fb ? CRC_POLY : '0);             // Fold in polynomial
    end
    crc = acc;
  end

endmodule

`default_nettype wire

/* hdl/trg_link_pkg.sv */
`default_nettype none

package trg_link_pkg;

  // ----------------------------------------
  // Link geometry
  // ----------------------------------------
  localparam int CLUSTER_W         = 14;                            // One cluster word
  localparam int CLUSTERS_PER_LINK = 4;                             // Clusters on one fiber
  localparam int N_LINKS           = 4;                             // CR, CL, GR, GL
  localparam int N_CLUSTERS        = 8;                             // Clusters per BX from the finder
  localparam int PAYLOAD_W         = CLUSTER_W * CLUSTERS_PER_LINK; // 56 bit link payload
  localparam int BXN_W             = 12;                            // BX number width

  // ----------------------------------------
  // Timing
  // ----------------------------------------
  localparam int LAT_MARK_PERIOD_LOG2 = 7;   // Latency marker every 128 BX
  localparam int RESET_HOLD           = 15;  // Extra idle cycles after reset
  localparam int RESET_CNT_W          = $clog2(RESET_HOLD + 1); // Stretch counter width

  // ----------------------------------------
  // CRC
  // ----------------------------------------
  localparam int CRC_W      = 8;                     // CRC-8
  localparam int CRC_DATA_W = 1 + BXN_W + PAYLOAD_W; // Overflow, bxn and payload, 69 bits

  localparam logic [CRC_W-1:0] CRC_POLY = 8'h07; // x^8 + x^2 + x + 1
  localparam logic [CRC_W-1:0] CRC_INIT = 8'h00; // Start value

  // ----------------------------------------
  // Types
  // ----------------------------------------
  typedef logic [CLUSTER_W-1:0] cluster_t; // Raw cluster word

  // Cluster 0 sits in the low bits of the payload
  typedef struct packed {
    cluster_t [CLUSTERS_PER_LINK-1:0] cl; // Four clusters
  } link_payload_t;

  // Header kind sent at the top of every frame
  typedef enum logic [1:0] {
    HDR_IDLE = 2'd0, // Link held or no BX yet
    HDR_DATA = 2'd1, // Ordinary BX
    HDR_BC0  = 2'd2, // Orbit start
    HDR_LAT  = 2'd3  // Latency marker
  } hdr_kind_t;

  // One link frame, 79 bits, MSB first as listed
  typedef struct packed {
    hdr_kind_t          hdr;      // Frame kind
    logic               overflow; // Cluster finder overflow
    logic [BXN_W-1:0]   bxn;      // BX number
    link_payload_t      payload;  // Four clusters
    logic [CRC_W-1:0]   crc;      // CRC-8 over overflow, bxn, payload
  } trg_frame_t;

endpackage

`default_nettype wire

/* hdl/trigger_links.sv */
`timescale 1ns/1ps
`default_nettype none

// Trigger link transmit side, four fibers at one frame per BX
module trigger_links (
  input  wire logic                                   clk_40,
  input  wire logic                                   reset,
  input  trg_link_pkg::cluster_t
           [trg_link_pkg::N_CLUSTERS-1:0]             clusters,
  input  wire logic [trg_link_pkg::BXN_W-1:0]         bxn_counter,
  input  wire logic                                   ttc_bx0,
  input  wire logic                                   overflow,
  output trg_link_pkg::trg_frame_t
           [trg_link_pkg::N_LINKS-1:0]                frames,
  output logic                                        link_ready
);

  import trg_link_pkg::*;

  // ----------------------------------------
  // Reset stretcher
  // ----------------------------------------
  logic [RESET_CNT_W-1:0] hold_cnt;    // Cycles of idle left after reset
  logic                   link_reset;  // Internal reset for the links

  always_ff @(posedge clk_40) begin
    if (reset) begin
      hold_cnt <= RESET_CNT_W'(RESET_HOLD);  // Reload while held
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;           // Count down to release
    end
  end

  assign link_reset = reset | (hold_cnt != '0); // Follows reset at once

  // Rises at the first edge with the links released
  always_ff @(posedge clk_40) begin
    if (link_reset) begin
      link_ready <= 1'b0;
    end else begin
      link_ready <= 1'b1;
    end
  end

  // ----------------------------------------
  // Cluster to link mapping
  // ----------------------------------------
  link_payload_t link_r;  // Right links, clusters 0 to 3
  link_payload_t link_l;  // Left links, clusters 4 to 7

  assign link_r.cl = clusters[CLUSTERS_PER_LINK-1:0];
  assign link_l.cl = clusters[N_CLUSTERS-1:CLUSTERS_PER_LINK];

  // ----------------------------------------
  // Shared header tag
  // ----------------------------------------
  hdr_kind_t tag;  // One BC0 and latency decision for all fibers

  bx_marker u_bx_marker (
    .clk_40      (clk_40),
    .link_reset  (link_reset),
    .ttc_bx0     (ttc_bx0),
    .bxn_counter (bxn_counter),
    .tag         (tag)
  );

  // ----------------------------------------
  // Fibers
  // ----------------------------------------
  // Even fibers carry the right payload, odd fibers the left one
  // 0 CSC right, 1 CSC left, 2 GEM right, 3 GEM left
  for (genvar i = 0; i < N_LINKS; i++) begin : g_fiber
    link_payload_t link_payload;  // Payload for this fiber

    assign link_payload = (i % 2 == 0) ? link_r : link_l;

    fiber_frame_out u_fiber (
      .clk_40      (clk_40),
      .link_reset  (link_reset),
      .payload     (link_payload),
      .bxn_counter (bxn_counter),
      .overflow    (overflow),
      .tag         (tag),
      .frame       (frames[i])
    );
  end

endmodule

`default_nettype wire

/* run_verilator.sh */
#!/usr/bin/env bash
# Build and run the trigger link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module trigger_links_tb \
  -Mdir obj_dir -o trigger_links_sim \
  > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/trigger_links_sim > sim.log 2>&1 \
  || { cat sim.log; echo "Simulation stopped with an error"; exit 1; }

cat sim.log

grep -q "Regression failed" sim.log && exit 1 || exit 0

/* sim/trigger_links_golden.txt */
// rst c0 c1 c2 c3 c4 c5 c6 c7 bxn bx0 ovf rdy, link0: hdr ovf bxn cl0 cl1 cl2 cl3 crc, link1 same
// All hex; expected frames come from the stimulus two lines up, links 2 and 3 copy 0 and 1
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  3fff 1 2 3 4 5 6 7  123 1 1  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  2aaa 1555 0 0 0 0 0 0  040 1 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  1 2 3 4 5 6 7 8  07f 0 1  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  1 0 0 0 2 0 0 0  081 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 10 0 0 0 20 0 0  082 0 0  1  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
0  0 0 100 0 0 0 200 0  084 0 0  1  1 0 081 1 0 0 0 ab  1 0 081 2 0 0 0 a2
0  0 0 0 2000 0 0 0 1  088 0 1  1  1 0 082 0 10 0 0 32  1 0 082 0 20 0 0 c8
0  3 0 0 0 800 0 0 0  100 0 0  1  1 0 084 0 0 100 0 c1  1 0 084 0 0 200 0 97
0  0 1 0 0 0 0 0 0  101 1 0  1  1 1 088 0 0 0 2000 28  1 1 088 0 0 0 1 06
0  0 0 0 0 0 0 0 0  180 1 0  1  3 0 100 3 0 0 0 70  3 0 100 800 0 0 0 d1
0  0 0 10 0 0 0 8 0  200 0 1  1  2 0 101 0 1 0 0 31  2 0 101 0 0 0 0 6a
0  0 0 0 4 0 0 0 100  201 0 0  1  2 0 180 0 0 0 0 c6  2 0 180 0 0 0 0 c6
0  1000 0 0 0 2000 0 0 0  400 0 0  1  3 1 200 0 0 10 0 15  3 1 200 0 0 8 0 46
0  0 0 0 0 0 0 0 0  800 0 0  1  1 0 201 0 0 0 4 7f  1 0 201 0 0 0 100 94
0  0 0 0 0 0 40 0 0  000 0 0  1  3 0 400 1000 0 0 0 b4  3 0 400 2000 0 0 0 4d
0  1 1 0 0 0 0 1 0  001 0 0  1  3 0 800 0 0 0 0 c1  3 0 800 0 0 0 0 c1
0  0 0 0 0 0 0 0 2  002 0 1  1  3 0 000 0 0 0 0 00  3 0 000 0 40 0 0 a2
0  0 0 0 0 0 0 0 0  003 1 0  1  1 0 001 1 1 0 0 4f  1 0 001 0 0 1 0 74
0  0 0 1 0 1 0 0 0  004 0 0  1  1 1 002 0 0 0 0 a3  1 1 002 0 0 0 2 ec
0  0 0 0 1 0 0 0 0  005 0 0  1  2 0 003 0 0 0 0 35  2 0 003 0 0 0 0 35
0  55 0 0 0 0 0 0 0  006 0 0  1  1 0 004 0 0 1 0 2b  1 0 004 1 0 0 0 4b
1  77 0 0 0 0 0 0 0  007 0 0  1  1 0 005 0 0 0 1 fb  1 0 005 0 0 0 0 5f
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00
1  0 0 0 0 0 0 0 0  000 0 0  0  0 0 000 0 0 0 0 00  0 0 000 0 0 0 0 00

/* sim/trigger_links_properties.sv */
`timescale 1ns/1ps
`default_nettype none

// Frame checks on one fiber builder
module trigger_links_properties (
  input wire logic                clk_40,
  input wire logic                link_reset,
  input trg_link_pkg::hdr_kind_t  tag,
  input trg_link_pkg::trg_frame_t frame
);

  import trg_link_pkg::*;

  // ----------------------------------------
  // Reset behavior
  // ----------------------------------------
  a_reset_idle: assert property (
    @(posedge clk_40) link_reset |=> frame.hdr == HDR_IDLE  // Idle on the next frame
  ) else $error("frame header not idle after link_reset");

  a_held_stable: assert property (
    @(posedge clk_40) link_reset ##1 link_reset |=> $stable(frame)  // Held link is frozen
  ) else $error("frame changed while link_reset was held");

  // ----------------------------------------
  // Header kind
  // ----------------------------------------
  // BC0 outranks the latency marker
  a_bc0_not_lat: assert property (
    @(posedge clk_40) (!link_reset && tag == HDR_BC0) |=> frame.hdr != HDR_LAT
  ) else $error("latency marker sent in a BC0 frame");

endmodule

bind fiber_frame_out trigger_links_properties u_frame_props (
  .clk_40     (clk_40),
  .link_reset (link_reset),
  .tag        (tag),
  .frame      (frame)
);

`default_nettype wire

/* sim/trigger_links_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module trigger_links_tb;

  import trg_link_pkg::*;

  // ----------------------------------------
  // Bench constants
  // ----------------------------------------
  localparam int    CLK_HALF      = 20;  // 40 ns period
  localparam int    DRIVE_DELAY   = 2;   // Inputs change just after the edge
  localparam int    READY_TIMEOUT = 64;  // Cycles allowed for link_ready to rise
  localparam int    FIELDS        = 29;  // Columns in one golden line
  localparam string GOLDEN_FILE   = "sim/trigger_links_golden.txt";

  // ----------------------------------------
  // DUT signals
  // ----------------------------------------
  logic                      clk_40;
  logic                      reset;
  cluster_t [N_CLUSTERS-1:0] clusters;
  logic [BXN_W-1:0]          bxn_counter;
  logic                      ttc_bx0;
  logic                      overflow;
  trg_frame_t [N_LINKS-1:0]  frames;
  logic                      link_ready;

  logic [31:0] fields [FIELDS];  // Current golden line
  int          n_tests;
  int          n_errors;

  trigger_links UUT (
    .clk_40      (clk_40),
    .reset       (reset),
    .clusters    (clusters),
    .bxn_counter (bxn_counter),
    .ttc_bx0     (ttc_bx0),
    .overflow    (overflow),
    .frames      (frames),
    .link_ready  (link_ready)
  );

  initial begin
    clk_40 = 1'b0;
    forever #CLK_HALF clk_40 = ~clk_40;  // Free running BX clock
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("FAILED at %0t ns: %s got %h expected %h", $time, sig, got, exp);
    n_errors++;
  endtask

  task automatic check_frame(input string name, input trg_frame_t got, input trg_frame_t exp);
    if (got.hdr !== exp.hdr) report_mismatch({name, ".hdr"}, 64'(got.hdr), 64'(exp.hdr));
    if (got.overflow !== exp.overflow)
      report_mismatch({name, ".overflow"}, 64'(got.overflow), 64'(exp.overflow));
    if (got.bxn !== exp.bxn) report_mismatch({name, ".bxn"}, 64'(got.bxn), 64'(exp.bxn));
    if (got.payload !== exp.payload)
      report_mismatch({name, ".payload"}, 64'(got.payload), 64'(exp.payload));
    if (got.crc !== exp.crc) report_mismatch({name, ".crc"}, 64'(got.crc), 64'(exp.crc));
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) report_mismatch("link_ready", 64'(got), 64'(exp));
  endtask

  task automatic check_hold(input int got, input int exp);
    if (got != exp) report_mismatch("reset hold cycles", 64'(got), 64'(exp));
  endtask

  // ----------------------------------------
  // Golden file helpers
  // ----------------------------------------
  // Splits one line into hex columns
  task automatic parse_fields(input string text, output int count);
    int    start;
    logic  blank;
    string tok;
    count = 0;
    start = -1;
    for (int i = 0; i <= text.len(); i++) begin
      if (i == text.len()) begin
        blank = 1'b1;
      end else begin
        blank = (text.getc(i) == " " || text.getc(i) == "\t" ||
                 text.getc(i) == "\n" || text.getc(i) == "\r");
      end
      if (!blank && start < 0) begin
        start = i;  // Token begins
      end else if (blank && start >= 0) begin
        tok = text.substr(start, i - 1);
        if (count < FIELDS) fields[count] = tok.atohex();
        count++;
        start = -1;
      end
    end
  endtask

  // Expected frame from eight columns starting at base
  function automatic trg_frame_t expected_frame(input int base);
    trg_frame_t f;
    f.hdr      = hdr_kind_t'(fields[base][1:0]);
    f.overflow = fields[base+1][0];
    f.bxn      = fields[base+2][BXN_W-1:0];
    for (int j = 0; j < CLUSTERS_PER_LINK; j++) begin
      f.payload.cl[j] = fields[base+3+j][CLUSTER_W-1:0];  // Cluster 0 lowest
    end
    f.crc      = fields[base+7][7:0];
    return f;
  endfunction

  // One BX, check first, then drive the line's stimulus
  task automatic apply_line(input int line_no);
    trg_frame_t exp_r;
    trg_frame_t exp_l;
    int         errors_before;
    errors_before = n_errors;
    @(posedge clk_40);
    #DRIVE_DELAY;
    exp_r = expected_frame(13);  // Link 0, copied on link 2
    exp_l = expected_frame(21);  // Link 1, copied on link 3
    for (int i = 0; i < N_LINKS; i++) begin
      check_frame($sformatf("frames[%0d]", i), frames[i], (i % 2 == 0) ? exp_r : exp_l);
    end
    check_ready(link_ready, fields[12][0]);
    reset       = fields[0][0];
    for (int j = 0; j < N_CLUSTERS; j++) begin
      clusters[j] = fields[1+j][CLUSTER_W-1:0];
    end
    bxn_counter = fields[9][BXN_W-1:0];
    ttc_bx0     = fields[10][0];
    overflow    = fields[11][0];
    n_tests++;
    $display("golden line %0d: %0d mismatches", line_no, n_errors - errors_before);
  endtask

  // Release reset and time the stretch until link_ready
  task automatic check_release();
    int         cycles;
    trg_frame_t idle;
    idle     = '0;      // HDR_IDLE and zero content
    idle.crc = 8'h00;   // CRC-8 of zeros from a zero start
    cycles   = 0;
    @(posedge clk_40);
    #DRIVE_DELAY;
    reset = 1'b0;
    while (!link_ready && cycles < READY_TIMEOUT) begin
      @(posedge clk_40);
      #DRIVE_DELAY;
      cycles++;
    end
    n_tests++;
    if (!link_ready) begin
      $display("link_ready did not rise within %0d cycles of reset release", READY_TIMEOUT);
      n_errors++;
    end else begin
      check_hold(cycles, RESET_HOLD + 1);  // First released edge
      for (int i = 0; i < N_LINKS; i++) begin
        check_frame($sformatf("frames[%0d]", i), frames[i], idle);
      end
    end
    $display("reset release: link_ready after %0d cycles", cycles);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int    fd;
    int    code;
    int    count;
    int    line_no;
    string text;
    reset       = 1'b1;
    clusters    = '0;
    bxn_counter = '0;
    ttc_bx0     = 1'b0;
    overflow    = 1'b0;
    n_tests     = 0;
    n_errors    = 0;
    line_no     = 0;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open golden file %s", GOLDEN_FILE);
      n_errors++;
    end else begin
      while (!$feof(fd)) begin
        text = "";
        code = $fgets(text, fd);
        if (code == 0) break;
        if (text.len() > 0 && text.getc(0) == "/") continue;  // Column notes
        parse_fields(text, count);
        if (count == 0) continue;
        if (count != FIELDS) begin
          $display("Golden line %0d has %0d columns instead of %0d", line_no, count, FIELDS);
          n_errors++;
          continue;
        end
        apply_line(line_no);
        line_no++;
      end
      $fclose(fd);
      check_release();
    end
    $display("Tests run %0d, errors %0d", n_tests, n_errors);
    if (n_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
hdl/trg_link_pkg.sv
hdl/link_crc8.sv
hdl/bx_marker.sv
hdl/fiber_frame_out.sv
hdl/trigger_links.sv
sim/trigger_links_properties.sv
sim/trigger_links_tb.sv
